/* build.f */
common/dispatchPkg.sv
common/entryWriteIf.sv
rtl/dispatch/dispatchStage.sv
rtl/dispatch/intEntryBuilder.sv
rtl/dispatch/memEntryBuilder.sv
rtl/issueQueue/issueQueuePayload.sv
rtl/dispatchTop.sv
verification/dispatchTop_assertions.sv
verification/dispatchTb.sv

/* Makefile */
SOURCES := build.f $(wildcard common/*.sv rtl/*.sv rtl/*/*.sv verification/*.sv)

obj_dir/VdispatchTb: $(SOURCES)
	verilator --binary --timing --assert --top-module dispatchTb -f build.f

run: obj_dir/VdispatchTb
	./obj_dir/VdispatchTb +verilator+error+limit+10 > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Regression failed" sim.log; then exit 1; fi
	@grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* verification/dispatchTb.sv */
// ==========================================================================
// Dispatch testbench
// Random rename traffic with stall, clear and issue into the dispatch
// top level, plus a slot model that the bound checks compare against
// ==========================================================================

`timescale 1ns/1ps

module dispatchTb;

    localparam int NUM_OPS = 400;
    localparam int N = dispatchPkg::IQ_ENTRIES;

    logic ctrl;
    logic rstN;
    logic stall;
    logic clear;
    logic issue;
    logic [dispatchPkg::IQ_PTR_WIDTH-1:0] issuePtr;
    logic [dispatchPkg::IQ_PTR_WIDTH-1:0] readPtr;
    // Rename-side op, valid doubles as renValid
    dispatchPkg::DispatchRegPath stim;

    logic readValid;
    logic readIsMem;
    logic [dispatchPkg::PAYLOAD_WIDTH-1:0] readPayload;
    logic [dispatchPkg::AL_PTR_WIDTH-1:0] readActiveListPtr;
    logic [dispatchPkg::PREG_WIDTH-1:0] readPhyDst;
    logic [1:0] readSrcValid;

    // Slot model
    dispatchPkg::DispatchRegPath pipeOp;
    logic [N-1:0] expValid;
    logic expIsMem [N];
    logic [dispatchPkg::PAYLOAD_WIDTH-1:0] expPayload [N];
    logic [dispatchPkg::AL_PTR_WIDTH-1:0] expAlPtr [N];
    logic [dispatchPkg::PREG_WIDTH-1:0] expPhyDst [N];
    logic [1:0] expSrcValid [N];

    dispatchTop i_dispatchTop (
        .ctrl(ctrl), .rstN(rstN), .stall(stall), .clear(clear),
        .renValid(stim.valid), .renKind(stim.kind),
        .renOperandTypeA(stim.operandTypeA), .renOperandTypeB(stim.operandTypeB),
        .renPhySrcA(stim.phySrcA), .renPhySrcB(stim.phySrcB), .renPhyDst(stim.phyDst),
        .renWriteReg(stim.writeReg), .renIssueQueuePtr(stim.issueQueuePtr),
        .renActiveListPtr(stim.activeListPtr), .renLoadQueuePtr(stim.loadQueuePtr),
        .renStoreQueuePtr(stim.storeQueuePtr), .renBrPred(stim.brPred),
        .renOpField(stim.opField), .issue(issue), .issuePtr(issuePtr), .readPtr(readPtr),
        .readValid(readValid), .readIsMem(readIsMem), .readPayload(readPayload),
        .readActiveListPtr(readActiveListPtr), .readPhyDst(readPhyDst),
        .readSrcValid(readSrcValid)
    );

    bind dispatchTop dispatchTop_assertions checks (
        .ctrl(ctrl), .rstN(rstN), .readPtr(readPtr), .readValid(readValid),
        .readIsMem(readIsMem), .readPayload(readPayload),
        .readActiveListPtr(readActiveListPtr), .readPhyDst(readPhyDst),
        .readSrcValid(readSrcValid)
    );

    // Entry word as the issue side should decode it
    function automatic logic [dispatchPkg::PAYLOAD_WIDTH-1:0] expectedPayload(
        dispatchPkg::DispatchRegPath op);
        logic [1:0] types;
        types = {op.operandTypeA, op.operandTypeB};
        case (op.kind)
            dispatchPkg::OP_BRANCH: return {types, op.opField, op.brPred, 1'b0};
            // isStore, access size and offset sit in opField[14:0], no MSHR yet
            dispatchPkg::OP_MEM: return {op.opField[14:0], op.loadQueuePtr,
                                         op.storeQueuePtr, 3'b000};
            default: return {types, op.opField[3:0], op.opField[8:4], 13'd0};
        endcase
    endfunction

    always @(posedge ctrl) begin
        if (!rstN) begin
            pipeOp <= '0;
            expValid <= '0;
        end else begin
            if (!stall) begin
                pipeOp <= stim;
            end
            if (issue) begin
                expValid[issuePtr] <= 1'b0;
            end
            // Later assignment, so a same-slot write beats the issue
            if (pipeOp.valid && !stall && !clear && pipeOp.kind != dispatchPkg::OP_NONE) begin
                expValid[pipeOp.issueQueuePtr] <= 1'b1;
                expIsMem[pipeOp.issueQueuePtr] <= (pipeOp.kind == dispatchPkg::OP_MEM);
                expPayload[pipeOp.issueQueuePtr] <= expectedPayload(pipeOp);
                expAlPtr[pipeOp.issueQueuePtr] <= pipeOp.activeListPtr;
                expPhyDst[pipeOp.issueQueuePtr] <= pipeOp.phyDst;
                expSrcValid[pipeOp.issueQueuePtr] <=
                    {pipeOp.operandTypeA == dispatchPkg::OPERAND_REG,
                     pipeOp.operandTypeB == dispatchPkg::OPERAND_REG};
            end
        end
    end

    task automatic quietInputs();
        stim = '0;
        stall = 1'b0;
        clear = 1'b0;
        issue = 1'b0;
        issuePtr = '0;
    endtask

    task automatic applyReset();
        @(negedge ctrl);
        quietInputs();
        rstN = 1'b0;
        repeat (10) @(negedge ctrl);
        rstN = 1'b1;
    endtask

    // Every slot passes the read port once
    task automatic sweepSlots();
        for (int i = 0; i < N; i++) begin
            @(negedge ctrl);
            readPtr = dispatchPkg::IQ_PTR_WIDTH'(i);
        end
        @(negedge ctrl);
    endtask

    task automatic randomizeInputs();
        logic [63:0] bits;
        bits = {$urandom, $urandom};
        stim = bits[$bits(dispatchPkg::DispatchRegPath)-1:0];
        stall = ($urandom_range(3) == 0);
        clear = ($urandom_range(7) == 0);
        issue = ($urandom_range(4) == 0);
        issuePtr = dispatchPkg::IQ_PTR_WIDTH'($urandom);
        // Mostly watch the slot about to be written, or the one just issued
        case ($urandom_range(4))
            0: readPtr = pipeOp.issueQueuePtr;
            1: readPtr = stim.issueQueuePtr;
            2: readPtr = issuePtr;
            3: readPtr = dispatchPkg::IQ_PTR_WIDTH'($urandom);
            default: begin
            end
        endcase
    endtask

    initial begin
        ctrl = 1'b0;
        forever #2 ctrl = ~ctrl;
    end

    initial begin
        repeat (NUM_OPS * 10 + 200) @(posedge ctrl);
        $display("Watchdog timeout: the run did not reach its end in time");
        $display("Regression failed");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        wait (i_dispatchTop.checks.failCount != 0);
        $display("Regression failed");
        $fatal(1, "A read-port check failed");
    end

    initial begin
        void'($urandom(32'hefaf7fb4));
        rstN = 1'b0;
        readPtr = '0;
        quietInputs();
        applyReset();
        sweepSlots();
        repeat (NUM_OPS) begin
            @(negedge ctrl);
            randomizeInputs();
        end
        // Second reset must drop every live slot
        applyReset();
        sweepSlots();
        if (i_dispatchTop.checks.failCount != 0) begin
            $display("Regression failed");
            $fatal(1, "Checks failed during the run");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

/* verification/dispatchTop_assertions.sv */
// ==========================================================================
// Dispatch read-port checks
// Compares the issue-queue read port with the testbench slot model
// ==========================================================================

`timescale 1ns/1ps

module dispatchTop_assertions (
    input logic ctrl,
    input logic rstN,
    input logic [dispatchPkg::IQ_PTR_WIDTH-1:0] readPtr,
    input logic readValid,
    input logic readIsMem,
    input logic [dispatchPkg::PAYLOAD_WIDTH-1:0] readPayload,
    input logic [dispatchPkg::AL_PTR_WIDTH-1:0] readActiveListPtr,
    input logic [dispatchPkg::PREG_WIDTH-1:0] readPhyDst,
    input logic [1:0] readSrcValid
);

    int failCount = 0;

    validOk: assert property (@(posedge ctrl) disable iff (!rstN)
        readValid == dispatchTb.expValid[readPtr])
    else begin
        $error("CHECK FAILED at %0t: readValid expected %0b, actual %0b", $time,
            $sampled(dispatchTb.expValid[readPtr]), $sampled(readValid));
        failCount++;
    end

    // Entry fields only mean something in a live slot
    isMemOk: assert property (@(posedge ctrl) disable iff (!rstN)
        dispatchTb.expValid[readPtr] |-> readIsMem == dispatchTb.expIsMem[readPtr])
    else begin
        $error("CHECK FAILED at %0t: readIsMem expected %0b, actual %0b", $time,
            $sampled(dispatchTb.expIsMem[readPtr]), $sampled(readIsMem));
        failCount++;
    end

    payloadOk: assert property (@(posedge ctrl) disable iff (!rstN)
        dispatchTb.expValid[readPtr] |-> readPayload == dispatchTb.expPayload[readPtr])
    else begin
        $error("CHECK FAILED at %0t: readPayload expected %06h, actual %06h", $time,
            $sampled(dispatchTb.expPayload[readPtr]), $sampled(readPayload));
        failCount++;
    end

    alPtrOk: assert property (@(posedge ctrl) disable iff (!rstN)
        dispatchTb.expValid[readPtr] |-> readActiveListPtr == dispatchTb.expAlPtr[readPtr])
    else begin
        $error("CHECK FAILED at %0t: readActiveListPtr expected %0h, actual %0h", $time,
            $sampled(dispatchTb.expAlPtr[readPtr]), $sampled(readActiveListPtr));
        failCount++;
    end

    phyDstOk: assert property (@(posedge ctrl) disable iff (!rstN)
        dispatchTb.expValid[readPtr] |-> readPhyDst == dispatchTb.expPhyDst[readPtr])
    else begin
        $error("CHECK FAILED at %0t: readPhyDst expected %0h, actual %0h", $time,
            $sampled(dispatchTb.expPhyDst[readPtr]), $sampled(readPhyDst));
        failCount++;
    end

    srcValidOk: assert property (@(posedge ctrl) disable iff (!rstN)
        dispatchTb.expValid[readPtr] |-> readSrcValid == dispatchTb.expSrcValid[readPtr])
    else begin
        $error("CHECK FAILED at %0t: readSrcValid expected %02b, actual %02b", $time,
            $sampled(dispatchTb.expSrcValid[readPtr]), $sampled(readSrcValid));
        failCount++;
    end

endmodule

/* rtl/dispatchTop.sv */
// ==========================================================================
// Dispatch top level
// Rename-side ports into the dispatch stage, both entry builders and
// the issue-queue payload store
// ==========================================================================

`timescale 1ns/1ps

module dispatchTop (
    input logic ctrl,
    input logic rstN,
    input logic stall,
    input logic clear,
    input logic renValid,
    input dispatchPkg::OpKind renKind,
    input dispatchPkg::OperandType renOperandTypeA,
    input dispatchPkg::OperandType renOperandTypeB,
    input logic [dispatchPkg::PREG_WIDTH-1:0] renPhySrcA,
    input logic [dispatchPkg::PREG_WIDTH-1:0] renPhySrcB,
    input logic [dispatchPkg::PREG_WIDTH-1:0] renPhyDst,
    input logic renWriteReg,
    input logic [dispatchPkg::IQ_PTR_WIDTH-1:0] renIssueQueuePtr,
    input logic [dispatchPkg::AL_PTR_WIDTH-1:0] renActiveListPtr,
    input logic [dispatchPkg::LSQ_PTR_WIDTH-1:0] renLoadQueuePtr,
    input logic [dispatchPkg::LSQ_PTR_WIDTH-1:0] renStoreQueuePtr,
    input logic renBrPred,
    input logic [dispatchPkg::OP_FIELD_WIDTH-1:0] renOpField,
    input logic issue,
    input logic [dispatchPkg::IQ_PTR_WIDTH-1:0] issuePtr,
    input logic [dispatchPkg::IQ_PTR_WIDTH-1:0] readPtr,
    output logic readValid,
    output logic readIsMem,
    output logic [dispatchPkg::PAYLOAD_WIDTH-1:0] readPayload,
    output logic [dispatchPkg::AL_PTR_WIDTH-1:0] readActiveListPtr,
    output logic [dispatchPkg::PREG_WIDTH-1:0] readPhyDst,
    output logic [1:0] readSrcValid
);

    dispatchPkg::DispatchRegPath renOp;
    dispatchPkg::DispatchRegPath pipeReg;
    logic update;

    entryWriteIf intWrite ();
    entryWriteIf memWrite ();

    assign renOp = '{
        valid: renValid,
        kind: renKind,
        operandTypeA: renOperandTypeA,
        operandTypeB: renOperandTypeB,
        phySrcA: renPhySrcA,
        phySrcB: renPhySrcB,
        phyDst: renPhyDst,
        writeReg: renWriteReg,
        issueQueuePtr: renIssueQueuePtr,
        activeListPtr: renActiveListPtr,
        loadQueuePtr: renLoadQueuePtr,
        storeQueuePtr: renStoreQueuePtr,
        brPred: renBrPred,
        opField: renOpField
    };

    dispatchStage i_dispatchStage (
        .ctrl(ctrl), .rstN(rstN), .stall(stall), .clear(clear),
        .renValid(renValid), .renOp(renOp), .pipeReg(pipeReg), .update(update)
    );

    intEntryBuilder i_intEntryBuilder (.pipeReg(pipeReg), .update(update), .intWrite(intWrite));

    memEntryBuilder i_memEntryBuilder (.pipeReg(pipeReg), .update(update), .memWrite(memWrite));

    issueQueuePayload i_issueQueuePayload (
        .ctrl(ctrl), .rstN(rstN), .intWrite(intWrite), .memWrite(memWrite),
        .issue(issue), .issuePtr(issuePtr), .readPtr(readPtr),
        .readValid(readValid), .readIsMem(readIsMem), .readPayload(readPayload),
        .readActiveListPtr(readActiveListPtr), .readPhyDst(readPhyDst),
        .readSrcValid(readSrcValid)
    );

endmodule

/* rtl/issueQueue/issueQueuePayload.sv */
// ==========================================================================
// Issue-queue payload store
// Slot RAM written by the integer and memory builders, per-slot valid
// bits, and a combinational read port for the issue stage
// ==========================================================================

`timescale 1ns/1ps

module issueQueuePayload (
    input logic ctrl,
    input logic rstN,
    entryWriteIf.store intWrite,
    entryWriteIf.store memWrite,
    input logic issue,
    input logic [dispatchPkg::IQ_PTR_WIDTH-1:0] issuePtr,
    input logic [dispatchPkg::IQ_PTR_WIDTH-1:0] readPtr,
    output logic readValid,
    output logic readIsMem,
    output logic [dispatchPkg::PAYLOAD_WIDTH-1:0] readPayload,
    output logic [dispatchPkg::AL_PTR_WIDTH-1:0] readActiveListPtr,
    output logic [dispatchPkg::PREG_WIDTH-1:0] readPhyDst,
    output logic [1:0] readSrcValid
);

    logic [dispatchPkg::PAYLOAD_WIDTH-1:0] payloadRam [dispatchPkg::IQ_ENTRIES];
    logic [dispatchPkg::AL_PTR_WIDTH-1:0] alPtrRam [dispatchPkg::IQ_ENTRIES];
    logic [dispatchPkg::PREG_WIDTH-1:0] phyDstRam [dispatchPkg::IQ_ENTRIES];
    logic [1:0] srcValidRam [dispatchPkg::IQ_ENTRIES];
    logic isMemRam [dispatchPkg::IQ_ENTRIES];
    logic [dispatchPkg::IQ_ENTRIES-1:0] slotValid;

    logic wrEn;
    logic wrIsMem;

    // Only one builder writes per cycle since the stage holds a single op
    always_comb begin
        wrEn = intWrite.write || memWrite.write;
        wrIsMem = memWrite.write;
    end

    always_ff @(posedge ctrl) begin
        if (wrIsMem) begin
            payloadRam[memWrite.writePtr] <= memWrite.payload;
            alPtrRam[memWrite.writePtr] <= memWrite.activeListPtr;
            phyDstRam[memWrite.writePtr] <= memWrite.phyDst;
            srcValidRam[memWrite.writePtr] <= {memWrite.srcRegValidA, memWrite.srcRegValidB};
            isMemRam[memWrite.writePtr] <= 1'b1;
        end else if (intWrite.write) begin
            payloadRam[intWrite.writePtr] <= intWrite.payload;
            alPtrRam[intWrite.writePtr] <= intWrite.activeListPtr;
            phyDstRam[intWrite.writePtr] <= intWrite.phyDst;
            srcValidRam[intWrite.writePtr] <= {intWrite.srcRegValidA, intWrite.srcRegValidB};
            isMemRam[intWrite.writePtr] <= 1'b0;
        end
    end

    // Write comes after issue, so it wins on the same slot
    always_ff @(posedge ctrl) begin
        if (!rstN) begin
            slotValid <= '0;
        end else begin
            if (issue) begin
                slotValid[issuePtr] <= 1'b0;
            end
            if (wrEn) begin
                slotValid[wrIsMem ? memWrite.writePtr : intWrite.writePtr] <= 1'b1;
            end
        end
    end

    always_comb begin
        readValid = slotValid[readPtr];
        readIsMem = isMemRam[readPtr];
        readPayload = payloadRam[readPtr];
        readActiveListPtr = alPtrRam[readPtr];
        readPhyDst = phyDstRam[readPtr];
        // Bit 1 is operand A, bit 0 operand B
        readSrcValid = srcValidRam[readPtr];
    end

endmodule

/* rtl/dispatch/memEntryBuilder.sv */
// ==========================================================================
// Memory entry builder
// Turns a load or store into a memory-queue write carrying its
// load and store queue pointers
// ==========================================================================

`timescale 1ns/1ps

module memEntryBuilder (
    input dispatchPkg::DispatchRegPath pipeReg,
    input logic update,
    entryWriteIf.builder memWrite
);

    dispatchPkg::MemOpInfo memInfo;

    always_comb begin
        // Op field layout: isStore, access size, then the address offset
        memInfo.isStore = pipeReg.opField[14];
        memInfo.accessSize = pipeReg.opField[13:12];
        memInfo.addrOffset = pipeReg.opField[11:0];
        memInfo.loadQueuePtr = pipeReg.loadQueuePtr;
        memInfo.storeQueuePtr = pipeReg.storeQueuePtr;
        // No miss handler is held yet at dispatch
        memInfo.hasAllocatedMshr = 1'b0;
        memInfo.padding = '0;
    end

    always_comb begin
        memWrite.write = update && (pipeReg.kind == dispatchPkg::OP_MEM);
        memWrite.writePtr = pipeReg.issueQueuePtr;
        memWrite.activeListPtr = pipeReg.activeListPtr;
        memWrite.phyDst = pipeReg.phyDst;
        memWrite.writeReg = pipeReg.writeReg;
        memWrite.srcRegValidA = (pipeReg.operandTypeA == dispatchPkg::OPERAND_REG);
        memWrite.srcRegValidB = (pipeReg.operandTypeB == dispatchPkg::OPERAND_REG);
        memWrite.payload = memInfo;
    end

endmodule

/* rtl/dispatch/intEntryBuilder.sv */
// ==========================================================================
// Integer entry builder
// Turns the dispatched op into an integer-queue write, with the op info
// packed through either the ALU or the branch view
// ==========================================================================

`timescale 1ns/1ps

module intEntryBuilder (
    input dispatchPkg::DispatchRegPath pipeReg,
    input logic update,
    entryWriteIf.builder intWrite
);

    dispatchPkg::IntOpInfo opInfo;

    always_comb begin
        dispatchPkg::IntSubInfo intSub;
        dispatchPkg::BrSubInfo brSub;

        // ALU fields sit at the bottom of the rename op field
        intSub.operandTypeA = pipeReg.operandTypeA;
        intSub.operandTypeB = pipeReg.operandTypeB;
        intSub.aluCode = pipeReg.opField[3:0];
        intSub.shiftIn = pipeReg.opField[8:4];
        intSub.padding = '0;

        // Whole op field is the branch displacement
        brSub.operandTypeA = pipeReg.operandTypeA;
        brSub.operandTypeB = pipeReg.operandTypeB;
        brSub.brDisp = pipeReg.opField;
        brSub.brPred = pipeReg.brPred;
        brSub.padding = '0;

        if (pipeReg.kind == dispatchPkg::OP_BRANCH) begin
            opInfo.brSubInfo = brSub;
        end else begin
            opInfo.intSubInfo = intSub;
        end
    end

    always_comb begin
        intWrite.write = update && (pipeReg.kind == dispatchPkg::OP_ALU ||
                                    pipeReg.kind == dispatchPkg::OP_BRANCH);
        intWrite.writePtr = pipeReg.issueQueuePtr;
        intWrite.activeListPtr = pipeReg.activeListPtr;
        intWrite.phyDst = pipeReg.phyDst;
        intWrite.writeReg = pipeReg.writeReg;
        intWrite.srcRegValidA = (pipeReg.operandTypeA == dispatchPkg::OPERAND_REG);
        intWrite.srcRegValidB = (pipeReg.operandTypeB == dispatchPkg::OPERAND_REG);
        intWrite.payload = opInfo;
    end

endmodule

/* rtl/dispatch/dispatchStage.sv */
// ==========================================================================
// Dispatch stage
// Pipeline register between rename and the entry builders, with stall
// and clear, and the update strobe that allows a queue write
// ==========================================================================

`timescale 1ns/1ps

module dispatchStage (
    input logic ctrl,
    input logic rstN,
    input logic stall,
    input logic clear,
    input logic renValid,
    input dispatchPkg::DispatchRegPath renOp,
    output dispatchPkg::DispatchRegPath pipeReg,
    output logic update
);

    // Stall holds the current op, rename inputs are ignored
    always_ff @(posedge ctrl) begin
        if (!rstN) begin
            pipeReg <= '0;
        end else if (!stall) begin
            pipeReg <= renOp;
            // Valid comes from the rename handshake bit
            pipeReg.valid <= renValid;
        end else begin
            pipeReg <= pipeReg;
        end
    end

    // A cleared op is dropped and replaced at the next unstalled edge
    always_comb begin
        update = pipeReg.valid && !stall && !clear;
    end

endmodule

/* common/entryWriteIf.sv */
// ==========================================================================
// Issue-queue write request
// One entry write from an entry builder into the payload store
// ==========================================================================

`timescale 1ns/1ps

interface entryWriteIf;

    logic write;
    logic [dispatchPkg::IQ_PTR_WIDTH-1:0] writePtr;
    logic [dispatchPkg::AL_PTR_WIDTH-1:0] activeListPtr;
    logic [dispatchPkg::PREG_WIDTH-1:0] phyDst;
    logic writeReg;
    logic srcRegValidA;
    logic srcRegValidB;
    // Queue-specific entry word, decoded by the issue side
    logic [dispatchPkg::PAYLOAD_WIDTH-1:0] payload;

    modport builder (
        output write,
        output writePtr,
        output activeListPtr,
        output phyDst,
        output writeReg,
        output srcRegValidA,
        output srcRegValidB,
        output payload
    );

    modport store (
        input write,
        input writePtr,
        input activeListPtr,
        input phyDst,
        input writeReg,
        input srcRegValidA,
        input srcRegValidB,
        input payload
    );

endinterface

/* common/dispatchPkg.sv */
// ==========================================================================
// Dispatch package
// Sizes, op kinds, issue-queue entry layouts and the integer op-info
// union shared by the dispatch stage and the issue-queue payload store
// ==========================================================================

package dispatchPkg;

    localparam int IQ_ENTRIES = 8;
    localparam int IQ_PTR_WIDTH = 3;
    localparam int AL_PTR_WIDTH = 4;
    localparam int PREG_WIDTH = 6;
    localparam int LSQ_PTR_WIDTH = 3;
    localparam int PAYLOAD_WIDTH = 24;
    localparam int OP_FIELD_WIDTH = 20;

    // Both integer views fill the whole payload word
    localparam int INT_SUB_INFO_WIDTH = PAYLOAD_WIDTH;
    localparam int BR_SUB_INFO_WIDTH = PAYLOAD_WIDTH;

    typedef enum logic [1:0] {
        OP_ALU,
        OP_BRANCH,
        OP_MEM,
        OP_NONE
    } OpKind;

    typedef enum logic {
        OPERAND_REG,
        OPERAND_IMM
    } OperandType;

    // ALU view, padded up to the branch view
    typedef struct packed {
        OperandType operandTypeA;
        OperandType operandTypeB;
        logic [3:0] aluCode;
        logic [4:0] shiftIn;
        logic [INT_SUB_INFO_WIDTH-12:0] padding;
    } IntSubInfo;

    typedef struct packed {
        OperandType operandTypeA;
        OperandType operandTypeB;
        logic [OP_FIELD_WIDTH-1:0] brDisp;
        logic brPred;
        logic [BR_SUB_INFO_WIDTH-OP_FIELD_WIDTH-4:0] padding;
    } BrSubInfo;

    typedef struct packed {
        logic isStore;
        logic [1:0] accessSize;
        logic [11:0] addrOffset;
        logic [LSQ_PTR_WIDTH-1:0] loadQueuePtr;
        logic [LSQ_PTR_WIDTH-1:0] storeQueuePtr;
        logic hasAllocatedMshr;
        logic [PAYLOAD_WIDTH-2*LSQ_PTR_WIDTH-17:0] padding;
    } MemOpInfo;

    typedef struct packed {
        logic valid;
        OpKind kind;
        OperandType operandTypeA;
        OperandType operandTypeB;
        logic [PREG_WIDTH-1:0] phySrcA;
        logic [PREG_WIDTH-1:0] phySrcB;
        logic [PREG_WIDTH-1:0] phyDst;
        logic writeReg;
        logic [IQ_PTR_WIDTH-1:0] issueQueuePtr;
        logic [AL_PTR_WIDTH-1:0] activeListPtr;
        logic [LSQ_PTR_WIDTH-1:0] loadQueuePtr;
        logic [LSQ_PTR_WIDTH-1:0] storeQueuePtr;
        logic brPred;
        logic [OP_FIELD_WIDTH-1:0] opField;
    } DispatchRegPath;

    typedef union packed {
        IntSubInfo intSubInfo;
        BrSubInfo brSubInfo;
    } IntOpInfo;

endpackage
